/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_eeprom
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT := PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR TIMESCALE VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | awk '{ print } $$0 == "$(PASS_TEXT)" { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(BUILD_DIR)

/* design/apb_regs.sv */
module apb_regs (
    input  logic                           CLK,
    input  logic                           RESET,
    input  logic                           psel,
    input  logic                           penable,
    input  logic                           pwrite,
    input  logic [eeprom_pkg::APB_AW-1:0]  paddr,
    input  logic [eeprom_pkg::APB_DW-1:0]  pwdata,
    output logic [eeprom_pkg::APB_DW-1:0]  prdata,
    output logic                           pslverr,
    input  logic                           busy,
    input  logic                           done,
    input  logic                           nack,
    input  logic [7:0]                     rx_data,
    input  logic                           rx_valid,
    output logic                           go,
    output logic                           rd_mode,
    output eeprom_pkg::eeprom_addr_u       addr,
    output logic [7:0]                     wdata,
    output logic                           irq
);
    logic       wr_acc;
    logic       rd_acc;
    logic       cmd_wr;
    logic       done_st;
    logic       nack_st;
    logic [7:0] rdata_q;

    assign wr_acc  = psel && penable && pwrite;
    assign rd_acc  = psel && penable && !pwrite;
    assign cmd_wr  = wr_acc && (paddr == eeprom_pkg::REG_CMD);
    assign pslverr = cmd_wr && busy; // command refused mid transfer

    always_ff @(posedge CLK) begin
        if (RESET) begin
            go      <= 1'b0;
            rd_mode <= 1'b0;
            done_st <= 1'b0;
            nack_st <= 1'b0;
            irq     <= 1'b0;
        end else begin
            go <= 1'b0;
            if (cmd_wr && !busy && pwdata[eeprom_pkg::CMD_GO_BIT]) begin
                go      <= 1'b1;
                rd_mode <= pwdata[eeprom_pkg::CMD_READ_BIT];
                done_st <= 1'b0; // new transfer, fresh status
                nack_st <= 1'b0;
            end
            if (done) begin
                done_st <= 1'b1;
                nack_st <= nack;
                irq     <= 1'b1;
            end else if (rd_acc && paddr == eeprom_pkg::REG_STATUS) begin
                irq <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (wr_acc && paddr == eeprom_pkg::REG_ADDR)  addr.flat <= pwdata[10:0];
        if (wr_acc && paddr == eeprom_pkg::REG_WDATA) wdata <= pwdata[7:0];
        if (rx_valid) rdata_q <= rx_data;
    end

    always_comb begin
        prdata = '0;
        if (rd_acc) begin
            case (paddr)
                eeprom_pkg::REG_CMD:    prdata[eeprom_pkg::CMD_READ_BIT] = rd_mode;
                eeprom_pkg::REG_ADDR:   prdata[10:0] = addr.flat;
                eeprom_pkg::REG_WDATA:  prdata[7:0]  = wdata;
                eeprom_pkg::REG_STATUS: begin
                    prdata[eeprom_pkg::STAT_BUSY] = busy;
                    prdata[eeprom_pkg::STAT_DONE] = done_st;
                    prdata[eeprom_pkg::STAT_NACK] = nack_st;
                end
                eeprom_pkg::REG_RDATA:  prdata[7:0]  = rdata_q;
                default:                prdata = '0;
            endcase
        end
    end

    // error response only in an access phase that followed a setup phase
    a_slverr_access: assert property (@(posedge CLK) disable iff (RESET)
        pslverr |-> penable && $past(psel && !penable))
        else $error("pslverr outside apb access phase");

endmodule

/* design/byte_shifter.sv */
module byte_shifter (
    input  logic       CLK,
    input  logic       RESET,
    input  logic       low_mid,
    input  logic       high_mid,
    input  logic       load,
    input  logic       receive,
    input  logic [7:0] tx_byte,
    input  logic       ack_out,
    input  logic       sda_in,
    output logic       shift_bit,
    output logic [7:0] rx_byte,
    output logic       ack_in,
    output logic       frame_done
);
    logic [8:0] frame;  // slots still to present, 1 = release
    logic [3:0] slot;   // high_mid count within the frame
    logic       active;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            shift_bit  <= 1'b0;
            slot       <= 4'd0;
            active     <= 1'b0;
            ack_in     <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            if (load) begin
                shift_bit <= !receive && !tx_byte[7]; // msb first
                slot      <= 4'd0;
                active    <= 1'b1;
            end else if (low_mid && active) begin
                shift_bit <= !frame[7];
            end
            if (high_mid && active) begin
                slot <= slot + 4'd1;
                if (slot == 4'd8) begin
                    // ninth clock is the acknowledge slot
                    ack_in     <= sda_in;
                    frame_done <= 1'b1;
                    active     <= 1'b0;
                end
            end
        end
    end

    // shifter keeps its last slot on the bus until the next load
    always_ff @(posedge CLK) begin
        if (load) begin
            frame <= receive ? {8'hff, ack_out} : {tx_byte, 1'b1};
        end else if (low_mid && active) begin
            frame <= {frame[7:0], 1'b1};
        end
        if (high_mid && active && slot != 4'd8) begin
            rx_byte <= {rx_byte[6:0], sda_in};
        end
    end

endmodule

/* design/eeprom_pkg.sv */
package eeprom_pkg;

    localparam int APB_AW = 5;
    localparam int APB_DW = 32;

    localparam logic [APB_AW-1:0] REG_CMD    = 5'h00;
    localparam logic [APB_AW-1:0] REG_ADDR   = 5'h04;
    localparam logic [APB_AW-1:0] REG_WDATA  = 5'h08;
    localparam logic [APB_AW-1:0] REG_STATUS = 5'h0c;
    localparam logic [APB_AW-1:0] REG_RDATA  = 5'h10;

    localparam int CMD_GO_BIT   = 0;
    localparam int CMD_READ_BIT = 1; // 1 = random read, 0 = byte write

    localparam int STAT_BUSY = 0;
    localparam int STAT_DONE = 1;
    localparam int STAT_NACK = 2;

    localparam logic [3:0] DEV_TYPE = 4'b1010; // 24cxx family code
    localparam int         QTR      = 1;       // clk cycles per quarter scl

    // upper bits pick the 256-byte block, sent in the control byte
    typedef struct packed {
        logic [2:0] page;
        logic [7:0] word;
    } eeprom_pw_t;

    typedef union packed {
        logic [10:0] flat;
        eeprom_pw_t  pw;
    } eeprom_addr_u;

    typedef enum logic [3:0] {
        IDLE, START, CTRL_W, ADDR, DATA_W, RSTART, CTRL_R, DATA_R, STOP, FINISH
    } ctrl_state_e;

endpackage

/* design/eeprom_top.sv */
module eeprom_top (
    input  logic                           CLK,
    input  logic                           RESET,
    input  logic                           psel,
    input  logic                           penable,
    input  logic                           pwrite,
    input  logic [eeprom_pkg::APB_AW-1:0]  paddr,
    input  logic [eeprom_pkg::APB_DW-1:0]  pwdata,
    output logic [eeprom_pkg::APB_DW-1:0]  prdata,
    output logic                           pslverr,
    output logic                           irq,
    output logic                           scl,
    output logic                           sda_pull,
    input  logic                           sda_in
);
    logic                     go;
    logic                     rd_mode;
    eeprom_pkg::eeprom_addr_u addr;
    logic [7:0]               wdata;
    logic                     busy;
    logic                     done;
    logic                     nack;
    logic [7:0]               rx_data;
    logic                     rx_valid;
    logic                     run;
    logic                     low_mid;
    logic                     high_mid;
    logic                     fall;
    logic                     load;
    logic                     receive;
    logic [7:0]               tx_byte;
    logic                     ack_out;
    logic                     shift_bit;
    logic [7:0]               rx_byte;
    logic                     ack_in;
    logic                     frame_done;

    apb_regs regs_i (
        .CLK, .RESET, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pslverr,
        .busy, .done, .nack, .rx_data, .rx_valid, .go, .rd_mode, .addr, .wdata, .irq
    );

    scl_gen scl_i (
        .CLK, .RESET, .run, .scl, .low_mid, .rise (), .high_mid, .fall
    );

    byte_shifter shift_i (
        .CLK, .RESET, .low_mid, .high_mid, .load, .receive, .tx_byte, .ack_out,
        .sda_in, .shift_bit, .rx_byte, .ack_in, .frame_done
    );

    i2c_ctrl ctrl_i (
        .CLK, .RESET, .go, .rd_mode, .addr, .wdata, .low_mid, .high_mid, .fall,
        .frame_done, .ack_in, .rx_byte, .shift_bit, .busy, .done, .nack, .rx_data,
        .rx_valid, .run, .load, .receive, .tx_byte, .ack_out, .sda_pull
    );

endmodule

/* design/i2c_ctrl.sv */
module i2c_ctrl (
    input  logic                     CLK,
    input  logic                     RESET,
    input  logic                     go,
    input  logic                     rd_mode,
    input  eeprom_pkg::eeprom_addr_u addr,
    input  logic [7:0]               wdata,
    input  logic                     low_mid,
    input  logic                     high_mid,
    input  logic                     fall,
    input  logic                     frame_done,
    input  logic                     ack_in,
    input  logic [7:0]               rx_byte,
    input  logic                     shift_bit,
    output logic                     busy,
    output logic                     done,
    output logic                     nack,
    output logic [7:0]               rx_data,
    output logic                     rx_valid,
    output logic                     run,
    output logic                     load,
    output logic                     receive,
    output logic [7:0]               tx_byte,
    output logic                     ack_out,
    output logic                     sda_pull
);
    eeprom_pkg::ctrl_state_e state;
    eeprom_pkg::ctrl_state_e frame_next;
    logic       need_load;
    logic       frame_on;   // shifter owns sda
    logic       own_pull;   // start/stop level
    logic [1:0] cond_step;  // 0 waiting, 1 sda released, 2 condition made

    assign busy     = (state != eeprom_pkg::IDLE);
    assign done     = (state == eeprom_pkg::FINISH);
    assign run      = busy && !done;
    assign load     = need_load && low_mid;
    assign receive  = (state == eeprom_pkg::DATA_R);
    assign ack_out  = receive; // single byte read, master nacks it
    assign sda_pull = frame_on ? shift_bit : own_pull;

    always_comb begin
        tx_byte    = 8'h00;
        frame_next = eeprom_pkg::STOP;
        case (state)
            eeprom_pkg::CTRL_W: begin
                tx_byte    = {eeprom_pkg::DEV_TYPE, addr.pw.page, 1'b0};
                frame_next = eeprom_pkg::ADDR;
            end
            eeprom_pkg::ADDR: begin
                tx_byte    = addr.pw.word;
                frame_next = rd_mode ? eeprom_pkg::RSTART : eeprom_pkg::DATA_W;
            end
            eeprom_pkg::DATA_W: tx_byte = wdata;
            eeprom_pkg::CTRL_R: begin
                tx_byte    = {eeprom_pkg::DEV_TYPE, addr.pw.page, 1'b1};
                frame_next = eeprom_pkg::DATA_R;
            end
            default: tx_byte = 8'h00;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state     <= eeprom_pkg::IDLE;
            need_load <= 1'b0;
            frame_on  <= 1'b0;
            own_pull  <= 1'b0;
            cond_step <= 2'd0;
            nack      <= 1'b0;
            rx_valid  <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (load) begin
                need_load <= 1'b0;
                frame_on  <= 1'b1;
            end
            case (state)
                eeprom_pkg::IDLE: if (go) begin
                    nack      <= 1'b0;
                    cond_step <= 2'd0;
                    state     <= eeprom_pkg::START;
                end
                eeprom_pkg::START: begin
                    // bus idle already, so no release step
                    if (high_mid && cond_step == 2'd0) begin
                        own_pull  <= 1'b1;
                        cond_step <= 2'd2;
                    end
                    if (fall && cond_step == 2'd2) begin
                        cond_step <= 2'd0;
                        need_load <= 1'b1;
                        state     <= eeprom_pkg::CTRL_W;
                    end
                end
                eeprom_pkg::RSTART: begin
                    if (low_mid && cond_step == 2'd0) begin
                        frame_on  <= 1'b0;
                        own_pull  <= 1'b0; // let sda float up before scl rises
                        cond_step <= 2'd1;
                    end
                    if (high_mid && cond_step == 2'd1) begin
                        own_pull  <= 1'b1;
                        cond_step <= 2'd2;
                    end
                    if (fall && cond_step == 2'd2) begin
                        cond_step <= 2'd0;
                        need_load <= 1'b1;
                        state     <= eeprom_pkg::CTRL_R;
                    end
                end
                eeprom_pkg::STOP: begin
                    if (low_mid && cond_step == 2'd0) begin
                        frame_on  <= 1'b0;
                        own_pull  <= 1'b1; // low first, then rise while scl high
                        cond_step <= 2'd1;
                    end
                    if (high_mid && cond_step == 2'd1) begin
                        own_pull  <= 1'b0;
                        cond_step <= 2'd0;
                        state     <= eeprom_pkg::FINISH;
                    end
                end
                eeprom_pkg::FINISH: state <= eeprom_pkg::IDLE;
                default: if (frame_done) begin
                    if (ack_in && state != eeprom_pkg::DATA_R) begin
                        nack  <= 1'b1; // no ack from slave, abort
                        state <= eeprom_pkg::STOP;
                    end else begin
                        state     <= frame_next;
                        need_load <= frame_next inside {eeprom_pkg::ADDR,
                                                        eeprom_pkg::DATA_W,
                                                        eeprom_pkg::DATA_R};
                    end
                    rx_valid <= (state == eeprom_pkg::DATA_R);
                end
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (frame_done && state == eeprom_pkg::DATA_R) rx_data <= rx_byte;
    end

    a_sda_low_mid: assert property (@(posedge CLK) disable iff (RESET)
        $changed(sda_pull) |-> $past(low_mid) ||
            ($past(state) inside {eeprom_pkg::START, eeprom_pkg::RSTART, eeprom_pkg::STOP}))
        else $error("sda_pull changed while scl high outside start/stop");

    a_busy_done: assert property (@(posedge CLK) disable iff (RESET)
        $fell(busy) |-> $past(done))
        else $error("busy dropped without done");

endmodule

/* design/scl_gen.sv */
module scl_gen (
    input  logic CLK,
    input  logic RESET,
    input  logic run,
    output logic scl,
    output logic low_mid,
    output logic rise,
    output logic high_mid,
    output logic fall
);
    localparam int QW = (eeprom_pkg::QTR > 1) ? $clog2(eeprom_pkg::QTR) : 1;

    logic [QW-1:0] qcnt;
    logic [1:0]    phase; // 0,1 low  2,3 high
    logic          tick;

    assign tick = run && (qcnt == QW'(eeprom_pkg::QTR - 1));

    always_ff @(posedge CLK) begin
        if (RESET || !run) begin
            phase <= 2'd2; // parked high, next quarter is mid-high
            qcnt  <= '0;
        end else if (tick) begin
            phase <= phase + 2'd1;
            qcnt  <= '0;
        end else begin
            qcnt <= qcnt + 1'b1;
        end
    end

    assign scl = phase[1];

    // strobes fire in the last cycle of a quarter, so a registered
    // action lands exactly on the quarter boundary it is named after
    assign fall     = tick && (phase == 2'd3);
    assign low_mid  = tick && (phase == 2'd0);
    assign rise     = tick && (phase == 2'd1);
    assign high_mid = tick && (phase == 2'd2);

endmodule

/* project.f */
design/eeprom_pkg.sv
design/apb_regs.sv
design/scl_gen.sv
design/byte_shifter.sv
design/i2c_ctrl.sv
design/eeprom_top.sv
tests/eeprom_model.sv
tests/tb_eeprom.sv

/* tests/eeprom_model.sv */
module eeprom_model (
    input  logic scl,
    input  logic sda,
    input  logic present,
    output logic sda_pull
);
    timeunit 1ns;
    timeprecision 100ps;

    typedef enum logic [2:0] {M_IDLE, M_CTRL, M_WORD, M_WDATA, M_RDATA} mstate_e;

    logic [7:0]  mem [0:2047];
    mstate_e     st      = M_IDLE;
    mstate_e     st_next = M_IDLE;
    logic [3:0]  nbit    = 4'd0;  // scl rises seen in this frame
    logic [7:0]  sreg    = 8'h00;
    logic [7:0]  obyte   = 8'h00;
    logic [2:0]  page    = 3'd0;
    logic [7:0]  word    = 8'h00; // internal address counter
    logic [10:0] wr_addr = 11'd0;
    logic [7:0]  wr_byte = 8'h00;
    logic        wr_pend = 1'b0;
    logic        scl_q   = 1'b1;
    logic        sda_q   = 1'b1;

    initial begin
        sda_pull = 1'b0;
        for (int i = 0; i < 2048; i++) begin
            mem[i] = 8'(i) ^ 8'(i >> 3) ^ 8'h5a; // every address bit matters
        end
    end

    always @(posedge scl or negedge scl or posedge sda or negedge sda) begin
        if (scl && scl_q && sda_q && !sda) begin
            st       = M_CTRL; // start or repeated start
            nbit     = 4'd0;
            sda_pull = 1'b0;
            wr_pend  = 1'b0;
        end else if (scl && scl_q && !sda_q && sda) begin
            if (wr_pend) mem[wr_addr] = wr_byte; // write lands at stop
            wr_pend  = 1'b0;
            st       = M_IDLE;
            sda_pull = 1'b0;
        end else if (scl && !scl_q && st != M_IDLE) begin
            if (nbit < 4'd8 && st != M_RDATA) sreg = {sreg[6:0], sda};
            nbit = nbit + 4'd1;
        end else if (!scl && scl_q && st != M_IDLE) begin
            if (nbit == 4'd9) begin
                st       = st_next;
                nbit     = 4'd0;
                sda_pull = 1'b0;
                if (st == M_RDATA) begin
                    obyte    = mem[{page, word}];
                    word     = word + 8'd1;
                    sda_pull = !obyte[7];
                    st_next  = M_IDLE; // single byte, master nacks it
                end
            end else if (st == M_RDATA) begin
                if (nbit == 4'd8) begin
                    sda_pull = 1'b0; // master's ack slot
                end else if (nbit != 4'd0) begin
                    obyte    = {obyte[6:0], 1'b0};
                    sda_pull = !obyte[7];
                end
            end else if (nbit == 4'd8) begin
                sda_pull = present; // absent device never acks
                case (st)
                    M_CTRL: begin
                        if (sreg[7:4] != 4'b1010) sda_pull = 1'b0;
                        page    = sreg[3:1];
                        st_next = sreg[0] ? M_RDATA : M_WORD;
                    end
                    M_WORD: begin
                        word    = sreg;
                        st_next = M_WDATA;
                    end
                    M_WDATA: begin
                        wr_addr = {page, word};
                        wr_byte = sreg;
                        wr_pend = present;
                        word    = word + 8'd1;
                        st_next = M_WDATA;
                    end
                    default: st_next = M_IDLE;
                endcase
                if (!sda_pull) st_next = M_IDLE;
            end
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

/* tests/tb_eeprom.sv */
module tb_eeprom;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int SEED        = 32'h750c_195a;
    localparam int N_TRANSFERS = 62;
    localparam int CYCLE_LIMIT = 200 * N_TRANSFERS + 500;
    localparam int XFER_LIMIT  = 400;

    logic                          CLK;
    logic                          RESET;
    logic                          psel;
    logic                          penable;
    logic                          pwrite;
    logic [eeprom_pkg::APB_AW-1:0] paddr;
    logic [eeprom_pkg::APB_DW-1:0] pwdata;
    logic [eeprom_pkg::APB_DW-1:0] prdata;
    logic                          pslverr;
    logic                          irq;
    logic                          scl;
    logic                          sda_pull;
    logic                          sda_in;
    logic                          model_pull;
    logic                          present;

    logic [7:0]  shadow [0:2047];
    logic [7:0]  exp_q[$];
    logic [7:0]  act_q[$];
    logic [10:0] addr_q[$];
    int          value_errors = 0;
    int          other_errors = 0;
    int          cycles       = 0;

    assign sda_in = !(sda_pull || model_pull); // open drain, wired-and

    eeprom_top dut_i (
        .CLK, .RESET, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pslverr,
        .irq, .scl, .sda_pull, .sda_in
    );

    eeprom_model model_i (.scl, .sda (sda_in), .present, .sda_pull (model_pull));

    initial begin
        CLK = 1'b0;
        forever #2 CLK = !CLK;
    end

    function automatic logic [7:0] expected_byte(input logic [10:0] a);
        return shadow[a];
    endfunction

    function automatic logic [31:0] cmd_word(input logic rd);
        return (32'(1) << eeprom_pkg::CMD_GO_BIT) | (32'(rd) << eeprom_pkg::CMD_READ_BIT);
    endfunction

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error at %t: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    task automatic apb_write(input logic [eeprom_pkg::APB_AW-1:0] a,
                             input logic [31:0] d, output logic err);
        @(negedge CLK);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = a;
        pwdata  = d;
        @(negedge CLK);
        penable = 1'b1;
        #1 err = pslverr; // access cycle
        @(negedge CLK);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [eeprom_pkg::APB_AW-1:0] a, output logic [31:0] d);
        @(negedge CLK);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = a;
        @(negedge CLK);
        penable = 1'b1;
        #1 d = prdata;
        @(negedge CLK);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic wait_transfer(input logic expect_nack);
        logic [31:0]             st;
        logic [31:0]             exp_st;
        int                      n;
        eeprom_pkg::ctrl_state_e cs;
        n = 0;
        while (irq !== 1'b1 && n < XFER_LIMIT) begin
            @(negedge CLK);
            n++;
        end
        if (irq !== 1'b1) begin
            cs = dut_i.ctrl_i.state;
            $display("transfer raised no irq within %0d cycles, controller in %s",
                     XFER_LIMIT, cs.name());
            other_errors++;
        end
        exp_st = 32'(1) << eeprom_pkg::STAT_DONE;
        if (expect_nack) exp_st = exp_st | (32'(1) << eeprom_pkg::STAT_NACK);
        apb_read(eeprom_pkg::REG_STATUS, st);
        check("status", st, exp_st);
        check("irq", 32'(irq), 32'(0)); // cleared by the status read
    endtask

    task automatic write_byte(input logic [10:0] a, input logic [7:0] d,
                              input logic expect_nack);
        logic err;
        apb_write(eeprom_pkg::REG_ADDR, 32'(a), err);
        apb_write(eeprom_pkg::REG_WDATA, 32'(d), err);
        apb_write(eeprom_pkg::REG_CMD, cmd_word(1'b0), err);
        check("pslverr", 32'(err), 32'(0));
        wait_transfer(expect_nack);
        if (!expect_nack) shadow[a] = d;
    endtask

    task automatic read_byte(input logic [10:0] a, input logic expect_nack);
        logic        err;
        logic [31:0] rd;
        apb_write(eeprom_pkg::REG_ADDR, 32'(a), err);
        apb_write(eeprom_pkg::REG_CMD, cmd_word(1'b1), err);
        check("pslverr", 32'(err), 32'(0));
        wait_transfer(expect_nack);
        if (!expect_nack) begin
            apb_read(eeprom_pkg::REG_RDATA, rd);
            exp_q.push_back(expected_byte(a));
            addr_q.push_back(a);
            act_q.push_back(rd[7:0]);
        end
    endtask

    initial begin : compare_reads
        logic [7:0]  e;
        logic [7:0]  g;
        logic [10:0] ra;
        forever begin
            @(negedge CLK);
            while (act_q.size() > 0) begin
                g  = act_q.pop_front();
                e  = exp_q.pop_front();
                ra = addr_q.pop_front();
                check($sformatf("rdata[0x%03h]", ra), 32'(g), 32'(e));
            end
        end
    end

    initial begin : watchdog
        eeprom_pkg::ctrl_state_e cs;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge CLK);
            cycles++;
        end
        cs = dut_i.ctrl_i.state;
        $display("timeout: run passed %0d cycles, controller in %s", cycles, cs.name());
        other_errors++;
        finish_run();
    end

    initial begin : stimulus
        logic [31:0] st;
        logic        err;
        logic [10:0] a;
        logic [7:0]  d;
        $timeformat(-9, 1, " ns", 0);
        void'($urandom(SEED));
        RESET   = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        present = 1'b1;
        repeat (16) @(negedge CLK);
        RESET = 1'b0;
        for (int i = 0; i < 2048; i++) shadow[i] = model_i.mem[i]; // starting image

        // idle values
        @(negedge CLK);
        check("irq", 32'(irq), 32'(0));
        check("scl", 32'(scl), 32'(1));
        check("sda_pull", 32'(sda_pull), 32'(0));
        apb_read(eeprom_pkg::REG_STATUS, st);
        check("status", st, 32'(0));

        write_byte(11'h2a5, 8'hc3, 1'b0);
        read_byte(11'h2a5, 1'b0);

        // same word offset in all eight blocks
        for (int p = 0; p < 8; p++) write_byte({3'(p), 8'h5e}, 8'(p * 37 + 11), 1'b0);
        for (int p = 0; p < 8; p++) read_byte({3'(p), 8'h5e}, 1'b0);

        present = 1'b0;
        write_byte(11'h133, 8'h99, 1'b1);
        read_byte(11'h133, 1'b1);
        present = 1'b1;
        check("model mem[0x133]", 32'(model_i.mem[11'h133]), 32'(shadow[11'h133]));

        // second go while the write is on the bus
        a = 11'h4f0;
        d = 8'h6b;
        apb_write(eeprom_pkg::REG_ADDR, 32'(a), err);
        apb_write(eeprom_pkg::REG_WDATA, 32'(d), err);
        apb_write(eeprom_pkg::REG_CMD, cmd_word(1'b0), err);
        apb_read(eeprom_pkg::REG_STATUS, st);
        check("status", st, 32'(1) << eeprom_pkg::STAT_BUSY);
        apb_write(eeprom_pkg::REG_CMD, cmd_word(1'b1), err);
        check("pslverr", 32'(err), 32'(1));
        wait_transfer(1'b0);
        shadow[a] = d;
        read_byte(a, 1'b0);

        for (int i = 0; i < 40; i++) begin
            a = 11'($urandom) & 11'h703; // small pool so reads hit earlier writes
            if (($urandom & 1) != 0) write_byte(a, 8'($urandom), 1'b0);
            else read_byte(a, 1'b0);
        end

        for (int i = 0; i < 2048; i++) begin
            if (model_i.mem[i] !== shadow[i]) begin
                check($sformatf("model mem[0x%03h]", i), 32'(model_i.mem[i]), 32'(shadow[i]));
            end
        end
        repeat (2) @(negedge CLK);
        finish_run();
    end

endmodule
